// ==== source/soc_bus_pkg.sv ====
package soc_bus_pkg;

	// ====================
	// Sizes
	// ====================

	localparam int RAM_INDEX_BITS = 10;
	localparam int RAM_WORDS = 1024;
	localparam int LED_WIDTH = 10;

	// Bus vectors
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0] region_t;
	typedef logic [RAM_INDEX_BITS-1:0] ram_index_t;
	typedef logic [2:0] reg_offset_t;
	typedef logic [LED_WIDTH-1:0] led_t;

	// ====================
	// Memory map
	// ====================

	localparam region_t REGION_RAM = 4'h1;
	localparam region_t REGION_LED = 4'h4;
	localparam region_t REGION_TIMER = 4'hA;

	// Timer register offsets, in words
	localparam reg_offset_t TIMER_REG_CONTROL = 3'd0;
	localparam reg_offset_t TIMER_REG_COMPARE = 3'd1;
	localparam reg_offset_t TIMER_REG_COUNT = 3'd2;
	localparam reg_offset_t TIMER_REG_STATUS = 3'd3;

	// Read-only requester, e.g. instruction fetch
	typedef struct packed {
		logic req;
		addr_t addr;
	} fetch_req_t;

	// Read/write requester, rw high means write
	typedef struct packed {
		logic req;
		logic rw;
		addr_t addr;
		data_t wdata;
	} bus_req_t;

	typedef struct packed {
		logic ready;
		data_t rdata;
	} bus_rsp_t;

	typedef enum logic {
		ARB_IDLE,
		ARB_BUSY
	} arb_state_t;

endpackage

// ==== source/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter import soc_bus_pkg::*; (
	input logic clock,
	input logic i_rst,
	input fetch_req_t i_fetch,
	output bus_rsp_t o_fetch,
	input bus_req_t i_data,
	output bus_rsp_t o_data,
	input bus_req_t i_dma,
	output bus_rsp_t o_dma,
	output bus_req_t o_bus,
	input bus_rsp_t i_bus
);

	arb_state_t state;

	// One-hot owner of the bus, valid while busy
	logic own_data;
	logic own_dma;
	logic own_fetch;

	// ====================
	// Grant
	// ====================

	always_ff @(posedge clock) begin
		if (i_rst) begin
			state <= ARB_IDLE;
			own_data <= 1'b0;
			own_dma <= 1'b0;
			own_fetch <= 1'b0;
		end else begin
			case (state)
				ARB_IDLE: begin
					// Data first, then DMA, then fetch
					if (i_data.req || i_dma.req || i_fetch.req) begin
						state <= ARB_BUSY;
						own_data <= i_data.req;
						own_dma <= !i_data.req && i_dma.req;
						own_fetch <= !i_data.req && !i_dma.req && i_fetch.req;
					end
				end
				ARB_BUSY: begin
					// Back to idle one edge after the target answered
					if (i_bus.ready) begin
						state <= ARB_IDLE;
						own_data <= 1'b0;
						own_dma <= 1'b0;
						own_fetch <= 1'b0;
					end
				end
				default: begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	// ====================
	// Request forwarding
	// ====================

	always_comb begin
		o_bus = '0;
		if (state == ARB_BUSY) begin
			if (own_data) begin
				o_bus = i_data;
			end else if (own_dma) begin
				o_bus = i_dma;
			end else if (own_fetch) begin
				// Fetch port is always a read
				o_bus.req = i_fetch.req;
				o_bus.rw = 1'b0;
				o_bus.addr = i_fetch.addr;
				o_bus.wdata = '0;
			end
		end
	end

	// Ready only reaches the owner
	assign o_data = '{ready: own_data && i_bus.ready, rdata: i_bus.rdata};
	assign o_dma = '{ready: own_dma && i_bus.ready, rdata: i_bus.rdata};
	assign o_fetch = '{ready: own_fetch && i_bus.ready, rdata: i_bus.rdata};

endmodule

// ==== source/address_decoder.sv ====
`timescale 1ns/1ps

module address_decoder import soc_bus_pkg::*; (
	input logic clock,
	input logic i_rst,
	input bus_req_t i_bus,
	output bus_rsp_t o_bus,
	output bus_req_t o_ram,
	input bus_rsp_t i_ram,
	output bus_req_t o_ctrl,
	input bus_rsp_t i_ctrl,
	output logic o_bus_fault
);

	region_t region;
	logic sel_ram;
	logic sel_ctrl;
	logic sel_none;

	// Fault responder handshake
	logic fault_pending;
	logic fault_ready;

	assign region = i_bus.addr[31:28];
	assign sel_ram = (region == REGION_RAM);
	// LED and timer share one target
	assign sel_ctrl = (region == REGION_LED) || (region == REGION_TIMER);
	assign sel_none = !sel_ram && !sel_ctrl;

	// Qualify request per target
	always_comb begin
		o_ram = i_bus;
		o_ram.req = i_bus.req && sel_ram;
		o_ctrl = i_bus;
		o_ctrl.req = i_bus.req && sel_ctrl;
	end

	// Unmapped region completes anyway, so the bus never hangs
	always_ff @(posedge clock) begin
		if (i_rst) begin
			fault_pending <= 1'b0;
			fault_ready <= 1'b0;
		end else begin
			fault_pending <= i_bus.req && sel_none && !fault_pending && !fault_ready;
			fault_ready <= fault_pending;
		end
	end

	// Response mux
	always_comb begin
		if (sel_ram) begin
			o_bus = i_ram;
		end else if (sel_ctrl) begin
			o_bus = i_ctrl;
		end else begin
			o_bus.ready = fault_ready;
			o_bus.rdata = '0;
		end
	end

	assign o_bus_fault = fault_ready;

endmodule

// ==== source/block_ram.sv ====
`timescale 1ns/1ps

module block_ram import soc_bus_pkg::*; (
	input logic clock,
	input logic i_rst,
	input bus_req_t i_req,
	output bus_rsp_t o_rsp
);

	data_t mem [RAM_WORDS];

	ram_index_t index;
	logic pending;
	logic ready_q;
	data_t rdata_q;

	// Word index, upper address bits wrap inside the region
	assign index = i_req.addr[RAM_INDEX_BITS+1:2];

	// Accept, then answer one edge later
	always_ff @(posedge clock) begin
		if (i_rst) begin
			pending <= 1'b0;
			ready_q <= 1'b0;
		end else begin
			pending <= i_req.req && !pending && !ready_q;
			ready_q <= pending;
		end
	end

	// Storage and registered read port
	always_ff @(posedge clock) begin
		if (pending) begin
			if (i_req.rw) begin
				mem[index] <= i_req.wdata;
			end
			rdata_q <= mem[index];
		end
	end

	assign o_rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

// ==== source/system_control.sv ====
`timescale 1ns/1ps

module system_control import soc_bus_pkg::*; (
	input logic clock,
	input logic i_rst,
	input bus_req_t i_req,
	output bus_rsp_t o_rsp,
	output led_t o_led,
	output logic o_timer_irq
);

	region_t region;
	reg_offset_t offset;
	logic is_led;

	logic pending;
	logic ready_q;
	data_t rdata_q;
	data_t read_word;

	led_t led_q;

	// Timer state
	logic enable;
	logic irq_flag;
	data_t count;
	data_t compare;

	assign region = i_req.addr[31:28];
	assign offset = i_req.addr[4:2];
	// Anything else reaching this block is a timer access
	assign is_led = (region == REGION_LED);

	// ====================
	// Registers and timer
	// ====================

	always_ff @(posedge clock) begin
		if (i_rst) begin
			pending <= 1'b0;
			ready_q <= 1'b0;
			led_q <= '0;
			enable <= 1'b0;
			irq_flag <= 1'b0;
			count <= '0;
			compare <= '0;
		end else begin
			pending <= i_req.req && !pending && !ready_q;
			ready_q <= pending;

			// Free running while enabled, wraps on compare match
			if (enable) begin
				if (count == compare) begin
					count <= '0;
					irq_flag <= 1'b1;
				end else begin
					count <= count + 1'b1;
				end
			end

			// Bus writes take effect on the accept edge
			if (pending && i_req.rw) begin
				if (is_led) begin
					led_q <= i_req.wdata[LED_WIDTH-1:0];
				end else begin
					case (offset)
						TIMER_REG_CONTROL: enable <= i_req.wdata[0];
						TIMER_REG_COMPARE: compare <= i_req.wdata;
						TIMER_REG_STATUS: begin
							// Write one to clear
							if (i_req.wdata[0]) begin
								irq_flag <= 1'b0;
							end
						end
						default: begin
						end
					endcase
				end
			end
		end
	end

	// ====================
	// Read back
	// ====================

	always_comb begin
		read_word = '0;
		if (is_led) begin
			read_word = data_t'(led_q);
		end else begin
			case (offset)
				TIMER_REG_CONTROL: read_word = data_t'(enable);
				TIMER_REG_COMPARE: read_word = compare;
				TIMER_REG_COUNT: read_word = count;
				TIMER_REG_STATUS: read_word = data_t'(irq_flag);
				default: read_word = '0;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (pending) begin
			rdata_q <= read_word;
		end
	end

	assign o_rsp = '{ready: ready_q, rdata: rdata_q};
	assign o_led = led_q;
	assign o_timer_irq = irq_flag;

endmodule

// ==== source/soc_bus_top.sv ====
`timescale 1ns/1ps

module soc_bus_top import soc_bus_pkg::*; (
	input logic clock,
	input logic i_rst,
	input fetch_req_t i_fetch,
	output bus_rsp_t o_fetch,
	input bus_req_t i_data,
	output bus_rsp_t o_data,
	input bus_req_t i_dma,
	output bus_rsp_t o_dma,
	output led_t o_led,
	output logic o_timer_irq,
	output logic o_bus_fault
);

	// Single system bus
	bus_req_t bus_req;
	bus_rsp_t bus_rsp;

	// Per-target paths
	bus_req_t ram_req;
	bus_rsp_t ram_rsp;
	bus_req_t ctrl_req;
	bus_rsp_t ctrl_rsp;

	bus_arbiter arbiter (
		.clock(clock),
		.i_rst(i_rst),
		.i_fetch(i_fetch),
		.o_fetch(o_fetch),
		.i_data(i_data),
		.o_data(o_data),
		.i_dma(i_dma),
		.o_dma(o_dma),
		.o_bus(bus_req),
		.i_bus(bus_rsp)
	);

	address_decoder decoder (
		.clock(clock),
		.i_rst(i_rst),
		.i_bus(bus_req),
		.o_bus(bus_rsp),
		.o_ram(ram_req),
		.i_ram(ram_rsp),
		.o_ctrl(ctrl_req),
		.i_ctrl(ctrl_rsp),
		.o_bus_fault(o_bus_fault)
	);

	block_ram ram (
		.clock(clock),
		.i_rst(i_rst),
		.i_req(ram_req),
		.o_rsp(ram_rsp)
	);

	system_control control (
		.clock(clock),
		.i_rst(i_rst),
		.i_req(ctrl_req),
		.o_rsp(ctrl_rsp),
		.o_led(o_led),
		.o_timer_irq(o_timer_irq)
	);

endmodule

// ==== sim/soc_bus_tb.sv ====
`timescale 1ns/1ps

module soc_bus_tb import soc_bus_pkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 8;
	localparam int READY_LIMIT = 20;
	// Edges 0 to 2 of an uncontended access
	localparam int READY_EDGES = 3;
	localparam int STEP_CYCLES = 40;
	// Reset, priority and timer tests together
	localparam int TIMER_CYCLES = 400;
	localparam logic [1:0] PORT_DATA = 2'd0;
	localparam logic [1:0] PORT_DMA = 2'd1;
	localparam logic [1:0] PORT_FETCH = 2'd2;

	// One stimulus table entry
	typedef struct packed {
		logic [1:0] port;
		logic rw;
		addr_t addr;
		data_t wdata;
		// Compared on reads and faults
		data_t exp;
		logic fault;
	} step_t;

	logic clock;
	logic i_rst;
	fetch_req_t i_fetch;
	bus_req_t i_data;
	bus_req_t i_dma;
	bus_rsp_t o_fetch;
	bus_rsp_t o_data;
	bus_rsp_t o_dma;
	led_t o_led;
	logic o_timer_irq;
	logic o_bus_fault;

	step_t steps[$];
	data_t ram_model [RAM_WORDS];
	ram_index_t used[$];
	led_t led_expected;
	logic table_built;
	int value_errors;
	int handshake_errors;

	soc_bus_top UUT (
		.clock(clock),
		.i_rst(i_rst),
		.i_fetch(i_fetch),
		.o_fetch(o_fetch),
		.i_data(i_data),
		.o_data(o_data),
		.i_dma(i_dma),
		.o_dma(o_dma),
		.o_led(o_led),
		.o_timer_irq(o_timer_irq),
		.o_bus_fault(o_bus_fault)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// ====================
	// Helpers
	// ====================

	function automatic addr_t ram_addr(input ram_index_t idx);
		return 32'h1000_0000 | (addr_t'(idx) << 2);
	endfunction

	function automatic string port_name(input logic [1:0] port);
		case (port)
			PORT_DATA: return "o_data.rdata";
			PORT_DMA: return "o_dma.rdata";
			default: return "o_fetch.rdata";
		endcase
	endfunction

	function automatic bus_rsp_t port_rsp(input logic [1:0] port);
		case (port)
			PORT_DATA: return o_data;
			PORT_DMA: return o_dma;
			default: return o_fetch;
		endcase
	endfunction

	function automatic void add_step(input logic [1:0] port, input logic rw, input addr_t addr,
			input data_t wdata, input data_t exp, input logic fault);
		steps.push_back('{port: port, rw: rw, addr: addr, wdata: wdata, exp: exp, fault: fault});
	endfunction

	task automatic check_value(input string name, input data_t got, input data_t exp);
		assert (got === exp) else begin
			$display("** Error: %s is %h, expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic drive_port(input logic [1:0] port, input logic req, input logic rw,
			input addr_t addr, input data_t wdata);
		case (port)
			PORT_DATA: i_data = '{req: req, rw: rw, addr: addr, wdata: wdata};
			PORT_DMA: i_dma = '{req: req, rw: rw, addr: addr, wdata: wdata};
			default: i_fetch = '{req: req, addr: addr};
		endcase
	endtask

	// Holds the request through the cycle in which ready is high
	task automatic access(input logic [1:0] port, input logic rw, input addr_t addr,
			input data_t wdata, output data_t rdata, output logic fault, output int cycles);
		bus_rsp_t rsp;
		int waited;
		logic done;
		waited = 0;
		done = 1'b0;
		rdata = '0;
		fault = 1'b0;
		drive_port(port, 1'b1, rw, addr, wdata);
		while (!done && waited < READY_LIMIT) begin
			@(posedge clock);
			#1;
			waited++;
			rsp = port_rsp(port);
			if (rsp.ready) begin
				done = 1'b1;
				rdata = rsp.rdata;
				fault = o_bus_fault;
			end else begin
				check_value("o_bus_fault", data_t'(o_bus_fault), '0);
			end
		end
		if (done) begin
			// Request may change only after the edge that closes the ready cycle
			@(posedge clock);
			#1;
			rsp = port_rsp(port);
			assert (rsp.ready === 1'b0) else begin
				$display("Port %0d kept ready high for more than one cycle", port);
				handshake_errors++;
			end
			check_value("o_bus_fault", data_t'(o_bus_fault), '0);
		end
		drive_port(port, 1'b0, 1'b0, '0, '0);
		cycles = waited;
		if (!done) begin
			$display("Port %0d saw no ready within %0d cycles for address %h",
				port, READY_LIMIT, addr);
			handshake_errors++;
		end
	endtask

	task automatic run_step(input step_t s);
		data_t rdata;
		logic fault;
		int cycles;
		access(s.port, s.rw, s.addr, s.wdata, rdata, fault, cycles);
		assert (cycles == READY_EDGES) else begin
			$display("Port %0d saw ready after %0d edges instead of %0d",
				s.port, cycles, READY_EDGES);
			handshake_errors++;
		end
		check_value("o_bus_fault", data_t'(fault), data_t'(s.fault));
		if (!s.rw || s.fault) begin
			check_value(port_name(s.port), rdata, s.exp);
		end
	endtask

	// ====================
	// Stimulus table
	// ====================

	task automatic build_table();
		ram_index_t idx;
		data_t word;
		// Writes alternate between data and DMA ports
		for (int i = 0; i < 6; i++) begin
			idx = ram_index_t'($urandom);
			word = $urandom;
			ram_model[idx] = word;
			used.push_back(idx);
			add_step(i % 2 ? PORT_DMA : PORT_DATA, 1'b1, ram_addr(idx), word, '0, 1'b0);
		end
		for (int i = 0; i < 6; i++) begin
			add_step(2'(i % 3), 1'b0, ram_addr(used[i]), '0, ram_model[used[i]], 1'b0);
		end
		// Address bits above the index wrap
		add_step(PORT_FETCH, 1'b0, ram_addr(used[0]) + 32'h1000, '0, ram_model[used[0]], 1'b0);
		word = $urandom;
		led_expected = word[LED_WIDTH-1:0];
		add_step(PORT_DATA, 1'b1, 32'h4000_0000, word, '0, 1'b0);
		add_step(PORT_DMA, 1'b0, 32'h4000_0000, '0, data_t'(led_expected), 1'b0);
		// Unmapped region 0x7
		add_step(PORT_DATA, 1'b0, 32'h7000_0010, '0, '0, 1'b1);
		add_step(PORT_DMA, 1'b1, 32'h7000_0020, word, '0, 1'b1);
		table_built = 1'b1;
	endtask

	task automatic check_priority();
		data_t rd_data;
		data_t rd_dma;
		data_t rd_fetch;
		logic f_data;
		logic f_dma;
		logic f_fetch;
		int c_data;
		int c_dma;
		int c_fetch;
		time t_data;
		time t_dma;
		time t_fetch;
		fork
			begin
				access(PORT_DATA, 1'b0, ram_addr(used[1]), '0, rd_data, f_data, c_data);
				t_data = $time;
			end
			begin
				access(PORT_DMA, 1'b0, ram_addr(used[2]), '0, rd_dma, f_dma, c_dma);
				t_dma = $time;
			end
			begin
				access(PORT_FETCH, 1'b0, ram_addr(used[3]), '0, rd_fetch, f_fetch, c_fetch);
				t_fetch = $time;
			end
		join
		check_value("o_data.rdata", rd_data, ram_model[used[1]]);
		check_value("o_dma.rdata", rd_dma, ram_model[used[2]]);
		check_value("o_fetch.rdata", rd_fetch, ram_model[used[3]]);
		assert (t_data < t_dma && t_dma < t_fetch) else begin
			$display("Ready order is wrong: data at %0t, DMA at %0t, fetch at %0t",
				t_data, t_dma, t_fetch);
			value_errors++;
		end
	endtask

	task automatic check_timer();
		data_t rdata;
		logic fault;
		int cycles;
		int waited;
		access(PORT_DATA, 1'b1, 32'hA000_0004, 32'd20, rdata, fault, cycles);
		access(PORT_DATA, 1'b1, 32'hA000_0000, 32'd1, rdata, fault, cycles);
		waited = 0;
		while (!o_timer_irq && waited < 30) begin
			@(posedge clock);
			#1;
			waited++;
		end
		assert (o_timer_irq === 1'b1) else begin
			$display("Timer interrupt did not rise within 30 cycles");
			value_errors++;
		end
		access(PORT_DMA, 1'b0, 32'hA000_0008, '0, rdata, fault, cycles);
		assert (rdata <= 32'd20) else begin
			$display("** Error: o_dma.rdata is %h, expected at most %h", rdata, 32'd20);
			value_errors++;
		end
		access(PORT_FETCH, 1'b0, 32'hA000_000C, '0, rdata, fault, cycles);
		check_value("o_fetch.rdata", rdata, 32'd1);
		access(PORT_DATA, 1'b1, 32'hA000_000C, 32'd1, rdata, fault, cycles);
		check_value("o_timer_irq", data_t'(o_timer_irq), '0);
		// Disable, then clear once more in case it fired meanwhile
		access(PORT_DATA, 1'b1, 32'hA000_0000, 32'd0, rdata, fault, cycles);
		access(PORT_DATA, 1'b1, 32'hA000_000C, 32'd1, rdata, fault, cycles);
		for (int i = 0; i < 50; i++) begin
			@(posedge clock);
			#1;
			check_value("o_timer_irq", data_t'(o_timer_irq), '0);
		end
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		clock = 1'b0;
		i_rst = 1'b1;
		i_fetch = '0;
		i_data = '0;
		i_dma = '0;
		value_errors = 0;
		handshake_errors = 0;
		table_built = 1'b0;
		void'($urandom(64));
		build_table();
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		i_rst = 1'b0;
		check_value("o_led", data_t'(o_led), '0);
		check_value("o_timer_irq", data_t'(o_timer_irq), '0);
		check_value("o_bus_fault", data_t'(o_bus_fault), '0);
		foreach (steps[i]) begin
			run_step(steps[i]);
		end
		check_value("o_led", data_t'(o_led), data_t'(led_expected));
		check_priority();
		check_timer();
		$display("Checks done: %0d value errors, %0d handshake errors",
			value_errors, handshake_errors);
		if (value_errors == 0 && handshake_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Watchdog sized from the table length
	initial begin
		wait (table_built === 1'b1);
		#((steps.size() * STEP_CYCLES + TIMER_CYCLES) * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("Checks done: %0d value errors, %0d handshake errors",
			value_errors, handshake_errors);
		$display("Test failed");
		$finish;
	end

endmodule

// ==== soc_bus.f ====
source/soc_bus_pkg.sv
source/bus_arbiter.sv
source/address_decoder.sv
source/block_ram.sv
source/system_control.sv
source/soc_bus_top.sv
sim/soc_bus_tb.sv
